/* list.f */
src/tpg_pkg.sv
src/reset_sequencer.sv
src/tpg_frame_fsm.sv
src/tpg_byte_counter.sv
src/tpg_byte_mux.sv
src/frame_monitor.sv
src/udp_frame_tpg_top.sv
testbench/tb_clock_gen.sv
testbench/udp_frame_tpg_sva.sv
testbench/tb_udp_frame_tpg.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_udp_frame_tpg -o tb_udp_frame_tpg

status=0
output=$(./obj_dir/tb_udp_frame_tpg 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "TEST RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1

/* src/frame_monitor.sv */
`timescale 1ns/1ps

module frame_monitor
    import tpg_pkg::*;
(
    input  logic               temac_clk,
    input  logic               key1,
    input  logic               tx_valid,
    input  logic               rx_valid,
    output logic [COUNT_W-1:0] tx_frame_count,
    output logic [COUNT_W-1:0] rx_frame_count
);

    // bit 0 is tx, bit 1 is rx
    logic [1:0]         valid_q;        // sampled strobes
    logic [1:0]         valid_d;        // previous sample
    logic [1:0]         valid_rise;
    logic [COUNT_W-1:0] frame_cnt [2];

    assign valid_rise = valid_q & ~valid_d;

    // ----------------------------------------
    // sample, then count rising edges
    // ----------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            valid_q <= '0;
            valid_d <= '0;
            for (int i = 0; i < 2; i++)
                frame_cnt[i] <= '0;
        end
        else
        begin
            valid_q <= {rx_valid, tx_valid};
            valid_d <= valid_q;
            for (int i = 0; i < 2; i++)
            begin
                if (valid_rise[i])
                    frame_cnt[i] <= frame_cnt[i] + 1'b1;    // one per frame
            end
        end
    end

    assign tx_frame_count = frame_cnt[0];
    assign rx_frame_count = frame_cnt[1];

endmodule

/* src/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer #(
    parameter logic [7:0] SOFT_RESET_CYCLES = 8'd255
)
(
    input  logic key1,
    input  logic temac_clk,
    output logic seq_ready
);

    logic [7:0] soft_reset_cnt;     // cycles left before generation may start

    // ----------------------------------------
    // countdown after key release
    // ----------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            soft_reset_cnt <= SOFT_RESET_CYCLES;
        end
        else if (soft_reset_cnt != 8'd0)
        begin
            soft_reset_cnt <= soft_reset_cnt - 8'd1;
        end
        else
        begin
            soft_reset_cnt <= soft_reset_cnt;   // hold at zero
        end
    end

    // high from the cycle the count hits zero
    assign seq_ready = (soft_reset_cnt == 8'd0);

endmodule

/* src/tpg_byte_counter.sv */
`timescale 1ns/1ps

module tpg_byte_counter
    import tpg_pkg::*;
#(
    parameter logic [15:0] PAYLOAD_LEN = 16'd255,
    parameter logic [15:0] FRAME_NUM   = 16'd10,
    parameter logic [7:0]  IFG_CYCLES  = 8'd130
)
(
    input  logic        temac_clk,
    input  logic        key1,
    input  tpg_state_t  state,
    input  cnt_cmd_t    cnt_cmd,
    output logic [15:0] byte_index,
    output logic [15:0] frame_index,
    output logic        phase_last,
    output logic        frames_done
);

    // last index of each phase
    localparam logic [15:0] HEADER_END  = 16'(HEADER_BYTES - 1);
    localparam logic [15:0] PAYLOAD_END = PAYLOAD_LEN - 16'd1;
    localparam logic [15:0] GAP_END     = {8'd0, IFG_CYCLES} - 16'd1;

    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            byte_index  <= '0;
            frame_index <= '0;
        end
        else
        begin
            case (cnt_cmd)
                CNT_CLEAR:
                begin
                    byte_index <= '0;
                    if (state == ST_IDLE)
                        frame_index <= '0;  // fresh run starts at frame 0
                end
                CNT_STEP:
                    byte_index <= byte_index + 16'd1;
                CNT_NEXT_FRAME:
                begin
                    byte_index  <= '0;
                    frame_index <= frame_index + 16'd1;
                end
                default:
                    byte_index <= byte_index;
            endcase
        end
    end

    always_comb
    begin
        case (state)
            ST_HEADER:  phase_last = (byte_index == HEADER_END);
            ST_PAYLOAD: phase_last = (byte_index == PAYLOAD_END);
            ST_GAP:     phase_last = (byte_index == GAP_END);
            default:    phase_last = 1'b0;
        endcase
    end

    // frame count reaches FRAME_NUM once the running gap closes
    assign frames_done = ((frame_index + 16'd1) == FRAME_NUM);

endmodule

/* src/tpg_byte_mux.sv */
`timescale 1ns/1ps

module tpg_byte_mux
    import tpg_pkg::*;
#(
    parameter logic [15:0] HEADER0     = 16'haabb,
    parameter logic [15:0] HEADER1     = 16'hccdd,
    parameter logic [15:0] FRAME_TYPE  = 16'ha8b8,
    parameter logic [15:0] PAYLOAD_LEN = 16'd255
)
(
    input  logic        temac_clk,
    input  logic        key1,
    input  tpg_state_t  state,
    input  logic [15:0] byte_index,
    input  logic [15:0] frame_index,
    output tpg_beat_t   tx_beat
);

    localparam logic [15:0] FRAME_LEN = PAYLOAD_LEN + 16'(HEADER_BYTES);   // length field

    tpg_beat_t  beat_next;
    logic [7:0] header_byte;

    // ----------------------------------------
    // header byte, msb of each field first
    // ----------------------------------------
    always_comb
    begin
        case (byte_index[2:0])
            3'd0:    header_byte = HEADER0[15:8];
            3'd1:    header_byte = HEADER0[7:0];
            3'd2:    header_byte = HEADER1[15:8];
            3'd3:    header_byte = HEADER1[7:0];
            3'd4:    header_byte = FRAME_TYPE[15:8];
            3'd5:    header_byte = FRAME_TYPE[7:0];
            3'd6:    header_byte = FRAME_LEN[15:8];
            default: header_byte = FRAME_LEN[7:0];
        endcase
    end

    always_comb
    begin
        beat_next       = '0;   // gap, idle and done send nothing
        if (state == ST_HEADER)
        begin
            beat_next.data  = header_byte;
            beat_next.valid = 1'b1;
            beat_next.sof   = (byte_index == 16'd0);
        end
        else if (state == ST_PAYLOAD)
        begin
            beat_next.data  = frame_index[7:0] + byte_index[7:0];  // counting pattern
            beat_next.valid = 1'b1;
            beat_next.eof   = (byte_index == PAYLOAD_LEN - 16'd1);
        end
    end

    // one cycle behind the state
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            tx_beat <= '0;
        else
            tx_beat <= beat_next;
    end

endmodule

/* src/tpg_frame_fsm.sv */
`timescale 1ns/1ps

module tpg_frame_fsm
    import tpg_pkg::*;
(
    input  logic       temac_clk,
    input  logic       key1,
    input  logic       seq_ready,
    input  logic       tpg_enable,
    input  logic       phase_last,     // counter at end of current phase
    input  logic       frames_done,    // this gap closes the last frame
    output tpg_state_t state,
    output cnt_cmd_t   cnt_cmd,
    output logic       tpg_done
);

    tpg_state_t state_next;

    // ----------------------------------------
    // state register
    // ----------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // ----------------------------------------
    // next state and counter command
    // ----------------------------------------
    always_comb
    begin
        state_next = state;
        cnt_cmd    = CNT_STEP;
        case (state)
            ST_IDLE:
            begin
                cnt_cmd = CNT_CLEAR;
                if (seq_ready && tpg_enable)    // enable only looked at here
                    state_next = ST_HEADER;
            end
            ST_HEADER:
            begin
                if (phase_last)
                begin
                    cnt_cmd    = CNT_CLEAR;
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD:
            begin
                if (phase_last)
                begin
                    cnt_cmd    = CNT_CLEAR;
                    state_next = ST_GAP;
                end
            end
            ST_GAP:
            begin
                if (phase_last)
                begin
                    cnt_cmd    = CNT_NEXT_FRAME;
                    state_next = frames_done ? ST_DONE : ST_HEADER;
                end
            end
            ST_DONE:
            begin
                cnt_cmd = CNT_CLEAR;    // parked, only reset leaves
            end
            default:
            begin
                cnt_cmd    = CNT_CLEAR;
                state_next = ST_IDLE;
            end
        endcase
    end

    assign tpg_done = (state == ST_DONE);

endmodule

/* src/tpg_pkg.sv */
package tpg_pkg;

    // ----------------------------------------
    // frame layout
    // ----------------------------------------
    localparam int unsigned HEADER_BYTES = 8;   // header0, header1, type, length
    localparam int unsigned COUNT_W      = 32;  // monitor counter width

    // ----------------------------------------
    // generator phase
    // ----------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,  // waiting for ready and enable
        ST_HEADER  = 3'd1,
        ST_PAYLOAD = 3'd2,
        ST_GAP     = 3'd3,  // inter-frame gap, valid low
        ST_DONE    = 3'd4   // all frames sent, parked until reset
    } tpg_state_t;

    // ----------------------------------------
    // counter command from the FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        CNT_CLEAR      = 2'd0,  // byte index back to zero
        CNT_STEP       = 2'd1,  // next byte of the phase
        CNT_NEXT_FRAME = 2'd2   // gap closed, bump frame index
    } cnt_cmd_t;

    // one transmitted byte with its strobes
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sof;    // first beat of a frame
        logic       eof;    // last beat of a frame
    } tpg_beat_t;

endpackage

/* src/udp_frame_tpg_top.sv */
`timescale 1ns/1ps

module udp_frame_tpg_top
    import tpg_pkg::*;
#(
    parameter logic [15:0] HEADER0           = 16'haabb,
    parameter logic [15:0] HEADER1           = 16'hccdd,
    parameter logic [15:0] FRAME_TYPE        = 16'ha8b8,
    parameter logic [15:0] PAYLOAD_LEN       = 16'd255,
    parameter logic [15:0] FRAME_NUM         = 16'd10,
    parameter logic [7:0]  IFG_CYCLES        = 8'd130,
    parameter logic [7:0]  SOFT_RESET_CYCLES = 8'd255
)
(
    input  logic               temac_clk,
    input  logic               key1,
    input  logic               tpg_enable,
    input  logic               rx_valid,
    output tpg_beat_t          tx_beat,
    output logic               tpg_done,
    output logic [COUNT_W-1:0] tx_frame_count,
    output logic [COUNT_W-1:0] rx_frame_count
);

    logic        seq_ready;
    tpg_state_t  state;
    cnt_cmd_t    cnt_cmd;
    logic        phase_last;
    logic        frames_done;
    logic [15:0] byte_index;
    logic [15:0] frame_index;

    // ----------------------------------------
    // frame generator
    // ----------------------------------------
    reset_sequencer #(
        .SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
    ) u_reset_sequencer (
        .key1       (key1),
        .temac_clk  (temac_clk),
        .seq_ready  (seq_ready)
    );

    tpg_frame_fsm u_frame_fsm (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .seq_ready   (seq_ready),
        .tpg_enable  (tpg_enable),
        .phase_last  (phase_last),
        .frames_done (frames_done),
        .state       (state),
        .cnt_cmd     (cnt_cmd),
        .tpg_done    (tpg_done)
    );

    tpg_byte_counter #(
        .PAYLOAD_LEN (PAYLOAD_LEN),
        .FRAME_NUM   (FRAME_NUM),
        .IFG_CYCLES  (IFG_CYCLES)
    ) u_byte_counter (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .state       (state),
        .cnt_cmd     (cnt_cmd),
        .byte_index  (byte_index),
        .frame_index (frame_index),
        .phase_last  (phase_last),
        .frames_done (frames_done)
    );

    tpg_byte_mux #(
        .HEADER0     (HEADER0),
        .HEADER1     (HEADER1),
        .FRAME_TYPE  (FRAME_TYPE),
        .PAYLOAD_LEN (PAYLOAD_LEN)
    ) u_byte_mux (
        .temac_clk   (temac_clk),
        .key1        (key1),
        .state       (state),
        .byte_index  (byte_index),
        .frame_index (frame_index),
        .tx_beat     (tx_beat)
    );

    // debug counters on both directions
    frame_monitor u_frame_monitor (
        .temac_clk      (temac_clk),
        .key1           (key1),
        .tx_valid       (tx_beat.valid),
        .rx_valid       (rx_valid),
        .tx_frame_count (tx_frame_count),
        .rx_frame_count (rx_frame_count)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 10
)
(
    output logic temac_clk,
    output logic key1
);

    initial
    begin
        temac_clk = 1'b0;
        key1      = 1'b0;   // held in reset from time zero
        repeat (RESET_CYCLES) @(posedge temac_clk);
        key1 <= 1'b1;
    end

    always #(HALF_PERIOD_NS) temac_clk = ~temac_clk;

endmodule

/* testbench/tb_udp_frame_tpg.sv */
`timescale 1ns/1ps

module tb_udp_frame_tpg
    import tpg_pkg::*;
();

    localparam logic [15:0] HEADER0           = 16'haabb;
    localparam logic [15:0] HEADER1           = 16'hccdd;
    localparam logic [15:0] FRAME_TYPE        = 16'ha8b8;
    localparam logic [15:0] PAYLOAD_LEN       = 16'd16;
    localparam logic [15:0] FRAME_NUM         = 16'd4;
    localparam logic [7:0]  IFG_CYCLES        = 8'd12;
    localparam logic [7:0]  SOFT_RESET_CYCLES = 8'd20;
    localparam int FRAME_LEN       = int'(HEADER_BYTES) + int'(PAYLOAD_LEN);
    localparam int WATCHDOG_CYCLES = int'(FRAME_NUM) * (FRAME_LEN + int'(IFG_CYCLES))
                                     + int'(SOFT_RESET_CYCLES) + 200;

    logic               temac_clk;
    logic               key1;
    logic               tpg_enable;
    logic               rx_valid;
    tpg_beat_t          tx_beat;
    logic               tpg_done;
    logic [COUNT_W-1:0] tx_frame_count;
    logic [COUNT_W-1:0] rx_frame_count;
    int                 error_count = 0;
    int                 check_count = 0;

    tb_clock_gen #(.HALF_PERIOD_NS(4), .RESET_CYCLES(10)) u_clock_gen (
        .temac_clk (temac_clk),
        .key1      (key1)
    );

    udp_frame_tpg_top #(
        .HEADER0 (HEADER0), .HEADER1 (HEADER1), .FRAME_TYPE (FRAME_TYPE),
        .PAYLOAD_LEN (PAYLOAD_LEN), .FRAME_NUM (FRAME_NUM),
        .IFG_CYCLES (IFG_CYCLES), .SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
    ) DUT (
        .temac_clk (temac_clk), .key1 (key1), .tpg_enable (tpg_enable),
        .rx_valid (rx_valid), .tx_beat (tx_beat), .tpg_done (tpg_done),
        .tx_frame_count (tx_frame_count), .rx_frame_count (rx_frame_count)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
        end
    endtask

    // header fields in wire order, msb first
    function automatic logic [7:0] expected_header_byte(input int k);
        logic [63:0] hdr;
        hdr = {HEADER0, HEADER1, FRAME_TYPE, 16'(FRAME_LEN)};
        return hdr[63 - 8 * k -: 8];
    endfunction

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_idle_after_reset();
        int idle_cycles;
        idle_cycles = 20 + int'($urandom_range(15, 0));
        repeat (idle_cycles)
        begin
            @(negedge temac_clk);
            check_value(32'(tx_beat.valid), 32'd0, "valid while enable low");
            check_value(32'(tpg_done), 32'd0, "done while enable low");
            check_value(tx_frame_count, 32'd0, "tx count after reset");
            check_value(rx_frame_count, 32'd0, "rx count after reset");
        end
    endtask

    task automatic wait_for_valid(input int limit);
        int waited;
        waited = 0;
        @(negedge temac_clk);
        while (!tx_beat.valid && waited < limit)
        begin
            waited++;
            @(negedge temac_clk);
        end
        if (!tx_beat.valid)
        begin
            error_count++;
            $display("no valid beat came within %0d cycles of enable", limit);
        end
    endtask

    task automatic check_frame(input int f);
        logic [7:0] expected;
        for (int k = 0; k < FRAME_LEN; k++)
        begin
            if (k < int'(HEADER_BYTES))
                expected = expected_header_byte(k);
            else
                expected = 8'(f + k - int'(HEADER_BYTES));  // frame plus payload index
            check_value(32'(tx_beat.valid), 32'd1, $sformatf("frame %0d beat %0d valid", f, k));
            check_value(32'(tx_beat.data), 32'(expected),
                        $sformatf("frame %0d beat %0d data", f, k));
            check_value(32'(tx_beat.sof), 32'(k == 0), $sformatf("frame %0d beat %0d sof", f, k));
            check_value(32'(tx_beat.eof), 32'(k == FRAME_LEN - 1),
                        $sformatf("frame %0d beat %0d eof", f, k));
            @(negedge temac_clk);
        end
    endtask

    task automatic test_frame_stream();
        int gap_cycles;
        wait_for_valid(int'(SOFT_RESET_CYCLES) + 20);
        for (int f = 0; f < int'(FRAME_NUM); f++)
        begin
            check_frame(f);
            gap_cycles = 0;
            while (!tx_beat.valid && !tpg_done && gap_cycles <= int'(IFG_CYCLES))
            begin
                gap_cycles++;
                @(negedge temac_clk);
            end
            if (f < int'(FRAME_NUM) - 1)
            begin
                check_value(gap_cycles, 32'(IFG_CYCLES), $sformatf("gap after frame %0d", f));
                check_value(32'(tx_beat.valid), 32'd1, "next frame after gap");
            end
            else
            begin
                check_value(32'(tx_beat.valid), 32'd0, "valid after last frame");
            end
        end
    endtask

    task automatic test_done_state();
        int waited;
        waited = 0;
        while (!tpg_done && waited < 2 * int'(IFG_CYCLES))
        begin
            waited++;
            @(negedge temac_clk);
        end
        if (!tpg_done)
        begin
            error_count++;
            $display("tpg_done never rose after the last frame");
        end
        repeat (2 * int'(IFG_CYCLES))
        begin
            @(negedge temac_clk);
            check_value(32'(tpg_done), 32'd1, "done holds");
            check_value(32'(tx_beat.valid), 32'd0, "no valid after done");
        end
        check_value(tx_frame_count, 32'(FRAME_NUM), "tx frame count");
    endtask

    task automatic test_rx_bursts();
        int bursts;
        int burst_len;
        int idle_len;
        bursts = 4 + int'($urandom_range(2, 0));
        for (int b = 0; b < bursts; b++)
        begin
            burst_len = 1 + int'($urandom_range(5, 0));
            idle_len  = 1 + int'($urandom_range(5, 0));
            repeat (burst_len)
            begin
                @(posedge temac_clk);
                rx_valid <= 1'b1;
            end
            repeat (idle_len)
            begin
                @(posedge temac_clk);
                rx_valid <= 1'b0;
            end
        end
        repeat (10) @(negedge temac_clk);   // let the monitor settle
        check_value(rx_frame_count, 32'(bursts), "rx frame count");
        check_value(tx_frame_count, 32'(FRAME_NUM), "tx count after rx bursts");
    endtask

    // ----------------------------------------
    // sequence and watchdog
    // ----------------------------------------
    initial
    begin
        void'($urandom(32'h568c));
        tpg_enable = 1'b0;
        rx_valid   = 1'b0;
        @(posedge key1);
        test_idle_after_reset();
        @(posedge temac_clk);
        tpg_enable <= 1'b1;
        test_frame_stream();
        test_done_state();
        test_rx_bursts();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES + 10) @(posedge temac_clk);
        $display("simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* testbench/udp_frame_tpg_sva.sv */
`timescale 1ns/1ps

module udp_frame_tpg_sva
    import tpg_pkg::*;
#(
    parameter logic [7:0] IFG_CYCLES = 8'd130
)
(
    input logic      temac_clk,
    input logic      key1,
    input tpg_beat_t tx_beat,
    input logic      tpg_done
);

    logic [7:0] gap_left;   // idle cycles still owed after eof

    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
            gap_left <= '0;
        else if (tx_beat.eof)
            gap_left <= IFG_CYCLES;
        else if (gap_left != 8'd0)
            gap_left <= gap_left - 8'd1;
    end

    // ----------------------------------------
    // output strobe rules
    // ----------------------------------------
    strobe_with_valid: assert property (@(posedge temac_clk) disable iff (!key1)
        (tx_beat.sof || tx_beat.eof) |-> tx_beat.valid)
        else $error("sof or eof seen without valid");

    quiet_when_done: assert property (@(posedge temac_clk) disable iff (!key1)
        tpg_done |-> !tx_beat.valid)
        else $error("valid high after the generator finished");

    gap_after_eof: assert property (@(posedge temac_clk) disable iff (!key1)
        (gap_left != 8'd0) |-> !tx_beat.valid)
        else $error("valid high inside the inter-frame gap");

endmodule

bind udp_frame_tpg_top udp_frame_tpg_sva #(
    .IFG_CYCLES (IFG_CYCLES)
) u_sva (
    .temac_clk (temac_clk),
    .key1      (key1),
    .tx_beat   (tx_beat),
    .tpg_done  (tpg_done)
);
